// ==== build.f ====
+incdir+include
source/noc_pkg.sv
source/tile_pkg.sv
source/flit_fifo.sv
source/route_ctrl.sv
source/mesh_router.sv
source/tile_net_top.sv
test/tb_clock_gen.sv
test/tile_net_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       ?= tile_net_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard source/*.sv include/*.svh test/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tile_net_tb.sv ====
// Tile request network testbench
`timescale 1ns/100ps
`include "tile_net_macros.svh"

module tile_net_tb
   import noc_pkg::*;
   import tile_pkg::*;
   ();

   localparam x_cord_t x0_lp = 4'd5;
   localparam x_cord_t x1_lp = 4'd6;
   localparam int body_w_lp = `TN_PAYLOAD_W - 2;
   localparam int n_rand_lp = 40;
   localparam int n_pkts_lp = 3 + 7 + 8 + 4 * n_rand_lp;
   localparam int timeout_lp = 40 * n_pkts_lp + 200;

   logic        clk;
   logic        rst;
   logic [31:0] rand_state;
   int          cycles;

   // Source and exit numbering is endpoint 0, endpoint 1, west, east
   flit_t       src_flit [4];
   logic [3:0]  src_v;
   logic [3:0]  src_ready;
   logic [3:0]  out_rdy;
   logic [3:0]  out_v;
   flit_t       out_flit [4];
   logic        rand_on;

   logic        inj_ready_0, inj_ready_1, west_ready, east_ready;
   logic        dlv_v_0, dlv_v_1, west_v, east_v;
   payload_t    dlv_payload_0, dlv_payload_1;
   flit_t       west_flit, east_flit;

   // One queue of expected flits per source and exit
   flit_t       exp_q [16][$];

   tb_clock_gen #(.period_p(20.0)) clock_gen (.clk_o(clk));

   tile_net_top dut
     (.clk_i(clk)
      ,.rst_i(rst)
      ,.my_x_i(x0_lp)
      ,.inj_payload_0_i(src_flit[0][`TN_X_W +: `TN_PAYLOAD_W])
      ,.inj_dst_0_i(src_flit[0][`TN_X_W-1:0])
      ,.inj_v_0_i(src_v[0])
      ,.inj_ready_0_o(inj_ready_0)
      ,.inj_payload_1_i(src_flit[1][`TN_X_W +: `TN_PAYLOAD_W])
      ,.inj_dst_1_i(src_flit[1][`TN_X_W-1:0])
      ,.inj_v_1_i(src_v[1])
      ,.inj_ready_1_o(inj_ready_1)
      ,.dlv_payload_0_o(dlv_payload_0)
      ,.dlv_v_0_o(dlv_v_0)
      ,.dlv_ready_0_i(out_rdy[0])
      ,.dlv_payload_1_o(dlv_payload_1)
      ,.dlv_v_1_o(dlv_v_1)
      ,.dlv_ready_1_i(out_rdy[1])
      ,.west_flit_i(src_flit[2])
      ,.west_v_i(src_v[2])
      ,.west_ready_o(west_ready)
      ,.west_flit_o(west_flit)
      ,.west_v_o(west_v)
      ,.west_ready_i(out_rdy[2])
      ,.east_flit_i(src_flit[3])
      ,.east_v_i(src_v[3])
      ,.east_ready_o(east_ready)
      ,.east_flit_o(east_flit)
      ,.east_v_o(east_v)
      ,.east_ready_i(out_rdy[3])
      );

   assign src_ready = {east_ready, west_ready, inj_ready_1, inj_ready_0};
   assign out_v     = {east_v, west_v, dlv_v_1, dlv_v_0};
   assign out_flit[0] = {dlv_payload_0, x_cord_t'(0)};
   assign out_flit[1] = {dlv_payload_1, x_cord_t'(0)};
   assign out_flit[2] = west_flit;
   assign out_flit[3] = east_flit;

   function automatic logic [31:0] next_rand();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   // Walks the row hop by hop from the node the source enters
   function automatic int ref_exit(input int src, input x_cord_t dst);
      int      node;
      int      ex;
      x_cord_t col;
      node = (src == 1 || src == 3) ? 1 : 0;
      ex   = -1;
      for (int hop = 0; hop < 3; hop++)
      begin
         col = (node == 0) ? x0_lp : x1_lp;
         if (ex == -1)
         begin
            if (dst == col)
               ex = node;
            else if (dst < col)
            begin
               if (node == 0)
                  ex = 2;
               node = 0;
            end
            else
            begin
               if (node == 1)
                  ex = 3;
               node = 1;
            end
         end
      end
      return ex;
   endfunction

   function automatic int pending_count();
      int n;
      n = 0;
      for (int k = 0; k < 16; k++)
         n += exp_q[k].size();
      return n;
   endfunction

   task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      if (got !== exp)
      begin
         $display("Fail at %0t: %s, got %h expected %h", $time, what, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic take_output(input int x, input flit_t got);
      int    src;
      int    key;
      flit_t exp;
      src = int'(got[`TN_PAYLOAD_W+`TN_X_W-1 -: 2]);
      key = src * 4 + x;
      if (exp_q[key].size() == 0)
      begin
         $display("Packet %h from source %0d left on exit %0d where none was due", got, src, x);
         $display("SIMULATION FAILED");
         $fatal(1, "unexpected packet");
      end
      else
      begin
         exp = exp_q[key].pop_front();
         // Endpoints see the payload only
         if (x < 2)
            check_equal(got[`TN_X_W +: `TN_PAYLOAD_W], exp[`TN_X_W +: `TN_PAYLOAD_W],
                        $sformatf("payload at exit %0d", x));
         else
            check_equal(got, exp, $sformatf("flit at exit %0d", x));
      end
   endtask

   // Called on a falling edge and returns on the falling edge after the transfer
   task automatic send(input int s, input logic [body_w_lp-1:0] body, input x_cord_t dst);
      flit_t f;
      f = {2'(s), body, dst};
      src_flit[s] = f;
      src_v[s]    = 1'b1;
      while (!src_ready[s])
         @(negedge clk);
      exp_q[s * 4 + ref_exit(s, dst)].push_back(f);
      @(negedge clk);
      src_v[s] = 1'b0;
   endtask

   task automatic send_rand(input int s, input x_cord_t dst);
      logic [31:0] r;
      r = next_rand();
      send(s, r[body_w_lp-1:0], dst);
   endtask

   task automatic random_source(input int s);
      logic [31:0] r;
      x_cord_t     dst;
      for (int i = 0; i < n_rand_lp; i++)
      begin
         r = next_rand();
         repeat (r[1:0])
            @(negedge clk);
         // Mostly local columns and the rest anywhere in the row
         if (r[4:2] < 3'd5)
            dst = r[5] ? x1_lp : x0_lp;
         else
            dst = r[9:6];
         send_rand(s, dst);
      end
   endtask

   task automatic randomize_readies();
      logic [31:0] r;
      while (rand_on)
      begin
         @(negedge clk);
         r = next_rand();
         for (int x = 0; x < 4; x++)
            out_rdy[x] = (r[2*x +: 2] != 2'd0);
      end
      out_rdy = 4'hf;
   endtask

   task automatic wait_drain();
      while (pending_count() != 0)
         @(negedge clk);
   endtask

   // Outputs are stable from just after the falling edge to the next rising edge
   initial
   begin
      logic [3:0] stall;
      flit_t      held [4];
      stall = '0;
      forever
      begin
         @(negedge clk);
         #1;
         for (int x = 0; x < 4; x++)
         begin
            // A stalled output keeps its valid and flit until the transfer
            if (stall[x])
            begin
               check_equal(out_v[x], 1, $sformatf("valid held at exit %0d", x));
               check_equal(out_flit[x], held[x], $sformatf("flit held at exit %0d", x));
            end
            stall[x] = !rst && out_v[x] && !out_rdy[x];
            held[x]  = out_flit[x];
            if (!rst && out_v[x] && out_rdy[x])
               take_output(x, out_flit[x]);
         end
      end
   end

   initial
   begin
      cycles = 0;
      forever
      begin
         @(posedge clk);
         cycles++;
         if (cycles > timeout_lp)
         begin
            $display("Run went past %0d cycles without finishing", timeout_lp);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
         end
      end
   end

   initial
   begin
      logic seen_low;
      rand_state = 32'h2db9_254b;
      rst        = 1'b1;
      src_v      = '0;
      out_rdy    = 4'hf;
      rand_on    = 1'b0;
      seen_low   = 1'b0;
      for (int s = 0; s < 4; s++)
         src_flit[s] = '0;

      for (int c = 0; c < 10; c++)
      begin
         @(negedge clk);
         check_equal(out_v, 0, "valid during reset");
      end
      rst = 1'b0;
      repeat (2)
      begin
         @(negedge clk);
         check_equal(out_v, 0, "valid after reset");
      end

      // Local delivery with two back to back from endpoint 0
      send_rand(0, x0_lp);
      send_rand(0, x0_lp);
      send_rand(1, x1_lp);
      wait_drain();

      // Crossing and pass-through
      send_rand(0, x1_lp);
      send_rand(1, x0_lp);
      send_rand(0, 4'd2);
      send_rand(1, 4'd12);
      send_rand(0, 4'd14);
      send_rand(2, x1_lp);
      send_rand(3, x0_lp);
      wait_drain();

      // Back-pressure from endpoint 1
      out_rdy[1] = 1'b0;
      fork
         begin
            for (int i = 0; i < 8; i++)
               send_rand(0, x1_lp);
         end
         begin
            for (int c = 0; c < 30 && !seen_low; c++)
            begin
               @(negedge clk);
               if (!src_ready[0])
                  seen_low = 1'b1;
            end
            check_equal(seen_low, 1, "inj_ready_0 low under back-pressure");
            @(negedge clk);
            out_rdy[1] = 1'b1;
         end
      join
      wait_drain();

      // Contention from all four sources
      rand_on = 1'b1;
      fork
         begin
            fork
               random_source(0);
               random_source(1);
               random_source(2);
               random_source(3);
            join
            rand_on = 1'b0;
         end
         randomize_readies();
      join
      wait_drain();

      // Late duplicates would still show up here
      repeat (5)
         @(negedge clk);
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule : tile_net_tb

// ==== test/tb_clock_gen.sv ====
// Testbench clock source
`timescale 1ns/100ps

module tb_clock_gen
  #(parameter real period_p = 20.0)
  (output logic clk_o
  );

   initial
   begin
      clk_o = 1'b0;
      forever
         #(period_p / 2.0) clk_o = ~clk_o;
   end

endmodule : tb_clock_gen

// ==== source/tile_net_top.sv ====
// Two node tile request network
`timescale 1ns/100ps
`include "tile_net_macros.svh"

module tile_net_top
   import noc_pkg::*;
   import tile_pkg::*;
  (input              clk_i
   , input            rst_i

   , input x_cord_t   my_x_i

   , input payload_t  inj_payload_0_i
   , input x_cord_t   inj_dst_0_i
   , input            inj_v_0_i
   , output           inj_ready_0_o

   , input payload_t  inj_payload_1_i
   , input x_cord_t   inj_dst_1_i
   , input            inj_v_1_i
   , output           inj_ready_1_o

   , output payload_t dlv_payload_0_o
   , output           dlv_v_0_o
   , input            dlv_ready_0_i

   , output payload_t dlv_payload_1_o
   , output           dlv_v_1_o
   , input            dlv_ready_1_i

   , input flit_t     west_flit_i
   , input            west_v_i
   , output           west_ready_o
   , output flit_t    west_flit_o
   , output           west_v_o
   , input            west_ready_i

   , input flit_t     east_flit_i
   , input            east_v_i
   , output           east_ready_o
   , output flit_t    east_flit_o
   , output           east_v_o
   , input            east_ready_i
  );

   x_cord_t node1_x;
   flit_t   inj_flit_0, inj_flit_1;
   flit_t   dlv_flit_0, dlv_flit_1;

   // Node 0 east to node 1 west
   flit_t   n0_e_flit;
   logic    n0_e_v, n0_e_ready;

   // Node 1 west to node 0 east
   flit_t   n1_w_flit;
   logic    n1_w_v, n1_w_ready;

   assign node1_x = my_x_i + 1'b1;

   // Header is the destination column
   assign inj_flit_0 = {inj_payload_0_i, inj_dst_0_i};
   assign inj_flit_1 = {inj_payload_1_i, inj_dst_1_i};

   assign dlv_payload_0_o = dlv_flit_0[`TN_X_W +: `TN_PAYLOAD_W];
   assign dlv_payload_1_o = dlv_flit_1[`TN_X_W +: `TN_PAYLOAD_W];

   mesh_router node0
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.my_x_i(my_x_i)
      ,.in_flit_w_i(west_flit_i)
      ,.in_v_w_i(west_v_i)
      ,.in_ready_w_o(west_ready_o)
      ,.out_flit_w_o(west_flit_o)
      ,.out_v_w_o(west_v_o)
      ,.out_ready_w_i(west_ready_i)
      ,.in_flit_e_i(n1_w_flit)
      ,.in_v_e_i(n1_w_v)
      ,.in_ready_e_o(n1_w_ready)
      ,.out_flit_e_o(n0_e_flit)
      ,.out_v_e_o(n0_e_v)
      ,.out_ready_e_i(n0_e_ready)
      ,.in_flit_p_i(inj_flit_0)
      ,.in_v_p_i(inj_v_0_i)
      ,.in_ready_p_o(inj_ready_0_o)
      ,.out_flit_p_o(dlv_flit_0)
      ,.out_v_p_o(dlv_v_0_o)
      ,.out_ready_p_i(dlv_ready_0_i)
      );

   mesh_router node1
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.my_x_i(node1_x)
      ,.in_flit_w_i(n0_e_flit)
      ,.in_v_w_i(n0_e_v)
      ,.in_ready_w_o(n0_e_ready)
      ,.out_flit_w_o(n1_w_flit)
      ,.out_v_w_o(n1_w_v)
      ,.out_ready_w_i(n1_w_ready)
      ,.in_flit_e_i(east_flit_i)
      ,.in_v_e_i(east_v_i)
      ,.in_ready_e_o(east_ready_o)
      ,.out_flit_e_o(east_flit_o)
      ,.out_v_e_o(east_v_o)
      ,.out_ready_e_i(east_ready_i)
      ,.in_flit_p_i(inj_flit_1)
      ,.in_v_p_i(inj_v_1_i)
      ,.in_ready_p_o(inj_ready_1_o)
      ,.out_flit_p_o(dlv_flit_1)
      ,.out_v_p_o(dlv_v_1_o)
      ,.out_ready_p_i(dlv_ready_1_i)
      );

endmodule : tile_net_top

// ==== source/mesh_router.sv ====
// Single row router node
`timescale 1ns/100ps
`include "tile_net_macros.svh"

module mesh_router
   import noc_pkg::*;
  (input             clk_i
   , input           rst_i

   , input x_cord_t  my_x_i

   , input flit_t    in_flit_w_i
   , input           in_v_w_i
   , output          in_ready_w_o
   , output flit_t   out_flit_w_o
   , output          out_v_w_o
   , input           out_ready_w_i

   , input flit_t    in_flit_e_i
   , input           in_v_e_i
   , output          in_ready_e_o
   , output flit_t   out_flit_e_o
   , output          out_v_e_o
   , input           out_ready_e_i

   , input flit_t    in_flit_p_i
   , input           in_v_p_i
   , output          in_ready_p_o
   , output flit_t   out_flit_p_o
   , output          out_v_p_o
   , input           out_ready_p_i
  );

   flit_t head_w, head_e, head_p;
   logic  head_v_w, head_v_e, head_v_p;
   logic  pop_w, pop_e, pop_p;
   dir_e  sel_w, sel_e, sel_p;

   function automatic flit_t pick_head(input dir_e sel, input flit_t hw, input flit_t he,
                                       input flit_t hp);
      case (sel)
         e_dir_w: return hw;
         e_dir_e: return he;
         default: return hp;
      endcase
   endfunction

   flit_fifo fifo_w
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.in_flit_i(in_flit_w_i)
      ,.in_v_i(in_v_w_i)
      ,.in_ready_o(in_ready_w_o)
      ,.out_flit_o(head_w)
      ,.out_v_o(head_v_w)
      ,.out_ready_i(pop_w)
      );

   flit_fifo fifo_e
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.in_flit_i(in_flit_e_i)
      ,.in_v_i(in_v_e_i)
      ,.in_ready_o(in_ready_e_o)
      ,.out_flit_o(head_e)
      ,.out_v_o(head_v_e)
      ,.out_ready_i(pop_e)
      );

   flit_fifo fifo_p
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.in_flit_i(in_flit_p_i)
      ,.in_v_i(in_v_p_i)
      ,.in_ready_o(in_ready_p_o)
      ,.out_flit_o(head_p)
      ,.out_v_o(head_v_p)
      ,.out_ready_i(pop_p)
      );

   // Destination column is the low field of each head flit
   route_ctrl ctrl
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.my_x_i(my_x_i)
      ,.head_dst_w_i(head_w[`TN_X_W-1:0])
      ,.head_dst_e_i(head_e[`TN_X_W-1:0])
      ,.head_dst_p_i(head_p[`TN_X_W-1:0])
      ,.head_v_w_i(head_v_w)
      ,.head_v_e_i(head_v_e)
      ,.head_v_p_i(head_v_p)
      ,.out_ready_w_i(out_ready_w_i)
      ,.out_ready_e_i(out_ready_e_i)
      ,.out_ready_p_i(out_ready_p_i)
      ,.sel_w_o(sel_w)
      ,.sel_e_o(sel_e)
      ,.sel_p_o(sel_p)
      ,.out_v_w_o(out_v_w_o)
      ,.out_v_e_o(out_v_e_o)
      ,.out_v_p_o(out_v_p_o)
      ,.pop_w_o(pop_w)
      ,.pop_e_o(pop_e)
      ,.pop_p_o(pop_p)
      );

   assign out_flit_w_o = pick_head(sel_w, head_w, head_e, head_p);
   assign out_flit_e_o = pick_head(sel_e, head_w, head_e, head_p);
   assign out_flit_p_o = pick_head(sel_p, head_w, head_e, head_p);

endmodule : mesh_router

// ==== source/route_ctrl.sv ====
// Router route and arbitration control
`timescale 1ns/100ps

module route_ctrl
   import noc_pkg::*;
  (input             clk_i
   , input           rst_i

   , input x_cord_t  my_x_i

   , input x_cord_t  head_dst_w_i
   , input x_cord_t  head_dst_e_i
   , input x_cord_t  head_dst_p_i

   , input           head_v_w_i
   , input           head_v_e_i
   , input           head_v_p_i

   , input           out_ready_w_i
   , input           out_ready_e_i
   , input           out_ready_p_i

   , output dir_e    sel_w_o
   , output dir_e    sel_e_o
   , output dir_e    sel_p_o

   , output          out_v_w_o
   , output          out_v_e_o
   , output          out_v_p_o

   , output          pop_w_o
   , output          pop_e_o
   , output          pop_p_o
  );

   x_cord_t    head_dst [3];
   logic [2:0] head_v;
   logic [2:0] out_ready;
   dir_e       want [3];
   logic [2:0] req [3];
   dir_e       sel [3];
   logic [2:0] out_v;
   logic [2:0] xfer;
   logic [2:0] pop;

   // Grant state per output
   dir_e       last_q [3];
   dir_e       hold_sel_q [3];
   logic [2:0] hold_q;

   function automatic dir_e route_dir(input x_cord_t dst, input x_cord_t here);
      if (dst == here)
         return e_dir_p;
      else if (dst < here)
         return e_dir_w;
      return e_dir_e;
   endfunction

   // First requester after the last grant, in w e p order
   function automatic dir_e rr_pick(input logic [2:0] r, input dir_e last);
      dir_e pick;
      logic found;
      int   cand;
      pick  = e_dir_p;
      found = 1'b0;
      for (int k = 1; k <= 3; k++)
      begin
         cand = (int'(last) + k) % 3;
         if (!found && r[cand])
         begin
            pick  = dir_e'(cand);
            found = 1'b1;
         end
      end
      return pick;
   endfunction

   assign head_dst[e_dir_w] = head_dst_w_i;
   assign head_dst[e_dir_e] = head_dst_e_i;
   assign head_dst[e_dir_p] = head_dst_p_i;
   assign head_v    = {head_v_p_i, head_v_e_i, head_v_w_i};
   assign out_ready = {out_ready_p_i, out_ready_e_i, out_ready_w_i};

   always_comb
   begin
      for (int i = 0; i < 3; i++)
         want[i] = route_dir(head_dst[i], my_x_i);
      for (int o = 0; o < 3; o++)
      begin
         for (int i = 0; i < 3; i++)
            req[o][i] = head_v[i] && (want[i] == dir_e'(o));
         // A stalled output keeps its winner until the transfer
         sel[o]   = hold_q[o] ? hold_sel_q[o] : rr_pick(req[o], last_q[o]);
         out_v[o] = |req[o];
         xfer[o]  = out_v[o] & out_ready[o];
      end
      for (int i = 0; i < 3; i++)
         pop[i] = head_v[i] && xfer[want[i]] && (sel[want[i]] == dir_e'(i));
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         hold_q <= '0;
         for (int o = 0; o < 3; o++)
         begin
            last_q[o]     <= e_dir_p;
            hold_sel_q[o] <= e_dir_p;
         end
      end
      else
      begin
         for (int o = 0; o < 3; o++)
         begin
            if (xfer[o])
            begin
               last_q[o] <= sel[o];
               hold_q[o] <= 1'b0;
            end
            else if (out_v[o])
            begin
               hold_q[o]     <= 1'b1;
               hold_sel_q[o] <= sel[o];
            end
         end
      end
   end

   assign sel_w_o = sel[e_dir_w];
   assign sel_e_o = sel[e_dir_e];
   assign sel_p_o = sel[e_dir_p];

   assign out_v_w_o = out_v[e_dir_w];
   assign out_v_e_o = out_v[e_dir_e];
   assign out_v_p_o = out_v[e_dir_p];

   assign pop_w_o = pop[e_dir_w];
   assign pop_e_o = pop[e_dir_e];
   assign pop_p_o = pop[e_dir_p];

endmodule : route_ctrl

// ==== source/flit_fifo.sv ====
// Router input buffer
`timescale 1ns/100ps
`include "tile_net_macros.svh"

module flit_fifo
   import noc_pkg::*;
  (input           clk_i
   , input         rst_i

   , input flit_t  in_flit_i
   , input         in_v_i
   , output        in_ready_o

   , output flit_t out_flit_o
   , output        out_v_o
   , input         out_ready_i
  );

   localparam int depth_lp = `TN_FIFO_DEPTH;
   localparam int ptr_w_lp = (depth_lp > 1) ? $clog2(depth_lp) : 1;
   localparam int cnt_w_lp = $clog2(depth_lp + 1);

   flit_t               mem_q [depth_lp];
   logic [ptr_w_lp-1:0] wr_ptr_q;
   logic [ptr_w_lp-1:0] rd_ptr_q;
   logic [cnt_w_lp-1:0] count_q;
   logic                wr_en;
   logic                rd_en;

   function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] ptr);
      if (ptr == ptr_w_lp'(depth_lp - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   // Ready only looks at the registered count
   assign in_ready_o = (count_q != cnt_w_lp'(depth_lp));
   assign out_v_o    = (count_q != '0);
   assign out_flit_o = mem_q[rd_ptr_q];

   assign wr_en = in_v_i & in_ready_o;
   assign rd_en = out_v_o & out_ready_i;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr_q <= next_ptr(wr_ptr_q);
         if (rd_en)
            rd_ptr_q <= next_ptr(rd_ptr_q);
         if (wr_en != rd_en)
            count_q <= wr_en ? count_q + 1'b1 : count_q - 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (wr_en)
         mem_q[wr_ptr_q] <= in_flit_i;
   end

endmodule : flit_fifo

// ==== source/tile_pkg.sv ====
// Endpoint types
`include "tile_net_macros.svh"

package tile_pkg;

   // Request payload as seen by an endpoint, without the network header
   typedef logic [`TN_PAYLOAD_W-1:0] payload_t;

endpackage : tile_pkg

// ==== source/noc_pkg.sv ====
// Mesh network types
`include "tile_net_macros.svh"

package noc_pkg;

   // Column coordinate of a router node
   typedef logic [`TN_X_W-1:0] x_cord_t;

   // Payload sits above the destination column
   typedef logic [`TN_PAYLOAD_W+`TN_X_W-1:0] flit_t;

   // Router side, also used as an index and as the last-grant state
   typedef enum logic [1:0]
   {
      e_dir_w = 2'd0,
      e_dir_e = 2'd1,
      e_dir_p = 2'd2
   } dir_e;

endpackage : noc_pkg

// ==== include/tile_net_macros.svh ====
// Tile network sizing
`ifndef TILE_NET_MACROS_SVH
`define TILE_NET_MACROS_SVH

// Endpoint payload width in bits
`define TN_PAYLOAD_W 32

// Column coordinate width in bits
`define TN_X_W 4

// Entries in each router input buffer
`define TN_FIFO_DEPTH 2

`endif
